/* common/intercon_pkg.sv */
package intercon_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH       = 28;
    localparam int DATA_WIDTH       = 32;
    localparam int SEL_WIDTH        = DATA_WIDTH / 8;
    localparam int NUM_MASTERS      = 2;
    localparam int MASTER_IDX_WIDTH = $clog2(NUM_MASTERS);

    // Address field widths below the crate flag
    localparam int REGION_WIDTH = 13;
    localparam int OFFSET_WIDTH = 14;

    // Memory map
    localparam logic [REGION_WIDTH-1:0] REGION_BANK0 = 13'd0;
    localparam logic [REGION_WIDTH-1:0] REGION_BANK1 = 13'd1;

    // Register bank contents
    localparam int                    BANK_WORDS = 8;
    localparam logic [DATA_WIDTH-1:0] BANK0_ID   = 32'h54524630;
    localparam logic [DATA_WIDTH-1:0] BANK1_ID   = 32'h54524631;

    // Crate space RAM size in words, as log2
    localparam int CRATE_DEPTH_LOG2 = 8;

    typedef struct packed {
        logic                    crate;
        logic [REGION_WIDTH-1:0] region;
        logic [OFFSET_WIDTH-1:0] offset;
    } wb_addr_fields_t;

    // Same 28-bit word seen flat or split into fields
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        wb_addr_fields_t       f;
    } wb_addr_u;

endpackage

/* hdl/wb_rr_arbiter.sv */
`timescale 1ns/1ps

module wb_rr_arbiter (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [intercon_pkg::NUM_MASTERS-1:0] cyc_i,
    output logic [intercon_pkg::NUM_MASTERS-1:0] gnt_o
);
    import intercon_pkg::*;

    logic [NUM_MASTERS-1:0]      gnt_q;
    logic [NUM_MASTERS-1:0]      next_gnt;
    logic [MASTER_IDX_WIDTH-1:0] last_q;
    logic [MASTER_IDX_WIDTH-1:0] next_last;
    logic                        owner_active;

    // Owner keeps the bus as long as its cyc stays up
    assign owner_active = |(gnt_q & cyc_i);

    // Search starts just after the last served master
    always_comb begin
        int idx;
        next_gnt  = '0;
        next_last = last_q;
        for (int k = 1; k <= NUM_MASTERS; k++) begin
            idx = (int'(last_q) + k) % NUM_MASTERS;
            if (cyc_i[idx] && next_gnt == '0) begin
                next_gnt[idx] = 1'b1;
                next_last     = MASTER_IDX_WIDTH'(idx);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_q  <= '0;
            // Master 0 wins the first tie
            last_q <= MASTER_IDX_WIDTH'(NUM_MASTERS - 1);
        end else if (!owner_active) begin
            gnt_q  <= next_gnt;
            last_q <= next_last;
        end
    end

    assign gnt_o = gnt_q;

endmodule

/* intercon/bus_intercon.sv */
`timescale 1ns/1ps

module bus_intercon (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic [intercon_pkg::NUM_MASTERS-1:0] gnt_i,
    // Master 0
    input  logic                                 m0_cyc_i,
    input  logic                                 m0_stb_i,
    input  logic                                 m0_we_i,
    input  intercon_pkg::wb_addr_u               m0_adr_i,
    input  logic [intercon_pkg::DATA_WIDTH-1:0]  m0_dat_i,
    input  logic [intercon_pkg::SEL_WIDTH-1:0]   m0_sel_i,
    output logic [intercon_pkg::DATA_WIDTH-1:0]  m0_dat_o,
    output logic                                 m0_ack_o,
    output logic                                 m0_err_o,
    // Master 1
    input  logic                                 m1_cyc_i,
    input  logic                                 m1_stb_i,
    input  logic                                 m1_we_i,
    input  intercon_pkg::wb_addr_u               m1_adr_i,
    input  logic [intercon_pkg::DATA_WIDTH-1:0]  m1_dat_i,
    input  logic [intercon_pkg::SEL_WIDTH-1:0]   m1_sel_i,
    output logic [intercon_pkg::DATA_WIDTH-1:0]  m1_dat_o,
    output logic                                 m1_ack_o,
    output logic                                 m1_err_o,
    // Common slave bus
    output logic                                 s_stb_o,
    output logic                                 s_we_o,
    output intercon_pkg::wb_addr_u               s_adr_o,
    output logic [intercon_pkg::DATA_WIDTH-1:0]  s_dat_o,
    output logic [intercon_pkg::SEL_WIDTH-1:0]   s_sel_o,
    // Per slave
    output logic                                 b0_cyc_o,
    input  logic [intercon_pkg::DATA_WIDTH-1:0]  b0_dat_i,
    input  logic                                 b0_ack_i,
    output logic                                 b1_cyc_o,
    input  logic [intercon_pkg::DATA_WIDTH-1:0]  b1_dat_i,
    input  logic                                 b1_ack_i,
    output logic                                 ram_cyc_o,
    input  logic [intercon_pkg::DATA_WIDTH-1:0]  ram_dat_i,
    input  logic                                 ram_ack_i
);
    import intercon_pkg::*;

    logic                  cyc;
    logic                  stb;
    logic                  pick_m1;
    wb_addr_u              adr;
    logic                  sel_b0;
    logic                  sel_b1;
    logic                  sel_ram;
    logic                  unmapped;
    logic                  ack;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err_q;

    // Granted master drives the shared bus
    assign pick_m1 = gnt_i[1];
    assign cyc     = (m0_cyc_i & gnt_i[0]) | (m1_cyc_i & gnt_i[1]);
    assign stb     = (m0_stb_i & gnt_i[0]) | (m1_stb_i & gnt_i[1]);
    assign adr.raw = pick_m1 ? m1_adr_i.raw : m0_adr_i.raw;

    assign s_stb_o = stb;
    assign s_we_o  = pick_m1 ? m1_we_i : m0_we_i;
    assign s_adr_o = adr;
    assign s_dat_o = pick_m1 ? m1_dat_i : m0_dat_i;
    assign s_sel_o = pick_m1 ? m1_sel_i : m0_sel_i;

    // Address decode on the field view
    assign sel_ram  = adr.f.crate;
    assign sel_b0   = !adr.f.crate && (adr.f.region == REGION_BANK0);
    assign sel_b1   = !adr.f.crate && (adr.f.region == REGION_BANK1);
    assign unmapped = !(sel_ram || sel_b0 || sel_b1);

    assign b0_cyc_o  = cyc & sel_b0;
    assign b1_cyc_o  = cyc & sel_b1;
    assign ram_cyc_o = cyc & sel_ram;

    // Response from the decoded slave
    always_comb begin
        ack   = 1'b0;
        rdata = '0;
        if (sel_ram) begin
            ack   = ram_ack_i;
            rdata = ram_dat_i;
        end else if (sel_b1) begin
            ack   = b1_ack_i;
            rdata = b1_dat_i;
        end else if (sel_b0) begin
            ack   = b0_ack_i;
            rdata = b0_dat_i;
        end
    end

    // Unmapped strobe ends with a single-cycle err
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= cyc && stb && unmapped && !err_q;
        end
    end

    // Only the owner sees a response
    assign m0_dat_o = rdata;
    assign m1_dat_o = rdata;
    assign m0_ack_o = ack & gnt_i[0];
    assign m1_ack_o = ack & gnt_i[1];
    assign m0_err_o = err_q & gnt_i[0];
    assign m1_err_o = err_q & gnt_i[1];

endmodule

/* hdl/ctrl_reg_bank.sv */
`timescale 1ns/1ps

module ctrl_reg_bank #(
    parameter logic [31:0] BANK_ID = 32'h0
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                cyc_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  intercon_pkg::wb_addr_u              adr_i,
    input  logic [intercon_pkg::DATA_WIDTH-1:0] dat_i,
    input  logic [intercon_pkg::SEL_WIDTH-1:0]  sel_i,
    output logic [intercon_pkg::DATA_WIDTH-1:0] dat_o,
    output logic                                ack_o
);
    import intercon_pkg::*;

    logic [DATA_WIDTH-1:0]         regs [1:BANK_WORDS-1];
    logic [$clog2(BANK_WORDS)-1:0] word_idx;
    logic                          req;
    logic                          ack_q;
    logic [DATA_WIDTH-1:0]         dat_q;

    // Upper offset bits alias onto the same eight words
    assign word_idx = adr_i.f.offset[4:2];

    // New access only while no ack is out
    assign req = cyc_i && stb_i && !ack_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            for (int w = 1; w < BANK_WORDS; w++) begin
                regs[w] <= '0;
            end
        end else begin
            ack_q <= req;
            // Word 0 is the ID and stays read-only
            if (req && we_i && word_idx != '0) begin
                for (int b = 0; b < SEL_WIDTH; b++) begin
                    if (sel_i[b]) begin
                        regs[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk_i) begin
        if (req) begin
            dat_q <= (word_idx == '0) ? BANK_ID : regs[word_idx];
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

endmodule

/* hdl/crate_ram.sv */
`timescale 1ns/1ps

module crate_ram #(
    parameter int DEPTH_LOG2 = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                cyc_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  intercon_pkg::wb_addr_u              adr_i,
    input  logic [intercon_pkg::DATA_WIDTH-1:0] dat_i,
    input  logic [intercon_pkg::SEL_WIDTH-1:0]  sel_i,
    output logic [intercon_pkg::DATA_WIDTH-1:0] dat_o,
    output logic                                ack_o
);
    import intercon_pkg::*;

    logic [DATA_WIDTH-1:0]                mem [0:(2**DEPTH_LOG2)-1];
    logic [REGION_WIDTH+OFFSET_WIDTH-1:0] crate_off;
    logic [DEPTH_LOG2-1:0]                word_idx;
    logic                                 wait_q;
    logic                                 ack_q;
    logic [DATA_WIDTH-1:0]                dat_q;

    // Crate space offset is everything under the flag
    assign crate_off = {adr_i.f.region, adr_i.f.offset};
    assign word_idx  = crate_off[DEPTH_LOG2+1:2];

    // First stage is the wait state, second one acks
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wait_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            wait_q <= cyc_i && stb_i && !wait_q && !ack_q;
            ack_q  <= wait_q;
        end
    end

    // Access happens as the wait state ends
    always_ff @(posedge clk_i) begin
        if (wait_q) begin
            dat_q <= mem[word_idx];
            if (we_i) begin
                for (int b = 0; b < SEL_WIDTH; b++) begin
                    if (sel_i[b]) begin
                        mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;

endmodule

/* hdl/ctrl_subsys_top.sv */
`timescale 1ns/1ps

module ctrl_subsys_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // Local processor port
    input  logic                                m0_cyc_i,
    input  logic                                m0_stb_i,
    input  logic                                m0_we_i,
    input  intercon_pkg::wb_addr_u              m0_adr_i,
    input  logic [intercon_pkg::DATA_WIDTH-1:0] m0_dat_i,
    input  logic [intercon_pkg::SEL_WIDTH-1:0]  m0_sel_i,
    output logic [intercon_pkg::DATA_WIDTH-1:0] m0_dat_o,
    output logic                                m0_ack_o,
    output logic                                m0_err_o,
    // Network bridge port
    input  logic                                m1_cyc_i,
    input  logic                                m1_stb_i,
    input  logic                                m1_we_i,
    input  intercon_pkg::wb_addr_u              m1_adr_i,
    input  logic [intercon_pkg::DATA_WIDTH-1:0] m1_dat_i,
    input  logic [intercon_pkg::SEL_WIDTH-1:0]  m1_sel_i,
    output logic [intercon_pkg::DATA_WIDTH-1:0] m1_dat_o,
    output logic                                m1_ack_o,
    output logic                                m1_err_o
);
    import intercon_pkg::*;

    logic [NUM_MASTERS-1:0] gnt;
    logic                   s_stb;
    logic                   s_we;
    wb_addr_u               s_adr;
    logic [DATA_WIDTH-1:0]  s_dat;
    logic [SEL_WIDTH-1:0]   s_sel;
    logic                   b0_cyc;
    logic                   b1_cyc;
    logic                   ram_cyc;
    logic [DATA_WIDTH-1:0]  b0_dat;
    logic [DATA_WIDTH-1:0]  b1_dat;
    logic [DATA_WIDTH-1:0]  ram_dat;
    logic                   b0_ack;
    logic                   b1_ack;
    logic                   ram_ack;

    wb_rr_arbiter u_arbiter (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i ({m1_cyc_i, m0_cyc_i}),
        .gnt_o (gnt)
    );

    bus_intercon u_intercon (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .gnt_i     (gnt),
        .m0_cyc_i  (m0_cyc_i),
        .m0_stb_i  (m0_stb_i),
        .m0_we_i   (m0_we_i),
        .m0_adr_i  (m0_adr_i),
        .m0_dat_i  (m0_dat_i),
        .m0_sel_i  (m0_sel_i),
        .m0_dat_o  (m0_dat_o),
        .m0_ack_o  (m0_ack_o),
        .m0_err_o  (m0_err_o),
        .m1_cyc_i  (m1_cyc_i),
        .m1_stb_i  (m1_stb_i),
        .m1_we_i   (m1_we_i),
        .m1_adr_i  (m1_adr_i),
        .m1_dat_i  (m1_dat_i),
        .m1_sel_i  (m1_sel_i),
        .m1_dat_o  (m1_dat_o),
        .m1_ack_o  (m1_ack_o),
        .m1_err_o  (m1_err_o),
        .s_stb_o   (s_stb),
        .s_we_o    (s_we),
        .s_adr_o   (s_adr),
        .s_dat_o   (s_dat),
        .s_sel_o   (s_sel),
        .b0_cyc_o  (b0_cyc),
        .b0_dat_i  (b0_dat),
        .b0_ack_i  (b0_ack),
        .b1_cyc_o  (b1_cyc),
        .b1_dat_i  (b1_dat),
        .b1_ack_i  (b1_ack),
        .ram_cyc_o (ram_cyc),
        .ram_dat_i (ram_dat),
        .ram_ack_i (ram_ack)
    );

    ctrl_reg_bank #(.BANK_ID(BANK0_ID)) u_bank0 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i (b0_cyc),
        .stb_i (s_stb),
        .we_i  (s_we),
        .adr_i (s_adr),
        .dat_i (s_dat),
        .sel_i (s_sel),
        .dat_o (b0_dat),
        .ack_o (b0_ack)
    );

    ctrl_reg_bank #(.BANK_ID(BANK1_ID)) u_bank1 (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i (b1_cyc),
        .stb_i (s_stb),
        .we_i  (s_we),
        .adr_i (s_adr),
        .dat_i (s_dat),
        .sel_i (s_sel),
        .dat_o (b1_dat),
        .ack_o (b1_ack)
    );

    // Stand-in for the crate bridge
    crate_ram #(.DEPTH_LOG2(CRATE_DEPTH_LOG2)) u_crate_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i (ram_cyc),
        .stb_i (s_stb),
        .we_i  (s_we),
        .adr_i (s_adr),
        .dat_i (s_dat),
        .sel_i (s_sel),
        .dat_o (ram_dat),
        .ack_o (ram_ack)
    );

endmodule

/* verif/ctrl_subsys_asserts.sv */
`timescale 1ns/1ps

module ctrl_subsys_asserts (
    input logic                                 clk_i,
    input logic                                 rst_i,
    input logic [intercon_pkg::NUM_MASTERS-1:0] gnt_i,
    input logic                                 m0_cyc_i,
    input logic                                 m1_cyc_i,
    input logic                                 m0_ack_i,
    input logic                                 m0_err_i,
    input logic                                 m1_ack_i,
    input logic                                 m1_err_i
);
    int assert_fails = 0;

    gnt_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_i))
        else begin
            $error("grant %b is not zero or one-hot", gnt_i);
            assert_fails = assert_fails + 1;
        end

    // Owner keeps the bus while its cyc is up
    gnt_held: assert property (@(posedge clk_i) disable iff (rst_i)
        (|(gnt_i & {m1_cyc_i, m0_cyc_i})) |=> $stable(gnt_i))
        else begin
            $error("grant changed while the owner held cyc");
            assert_fails = assert_fails + 1;
        end

    // A response belongs to a cycle the owner already had open a cycle earlier
    resp_to_owner: assert property (@(posedge clk_i) disable iff (rst_i)
        (!(m0_ack_i || m0_err_i) || (gnt_i[0] && $past(gnt_i[0] && m0_cyc_i))) &&
        (!(m1_ack_i || m1_err_i) || (gnt_i[1] && $past(gnt_i[1] && m1_cyc_i))))
        else begin
            $error("ack or err reached a master without the grant");
            assert_fails = assert_fails + 1;
        end

    ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(m0_ack_i && m0_err_i) && !(m1_ack_i && m1_err_i))
        else begin
            $error("ack and err high together");
            assert_fails = assert_fails + 1;
        end

    quiet_after_rst: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !(m0_ack_i || m0_err_i || m1_ack_i || m1_err_i))
        else begin
            $error("response in the first cycle after reset");
            assert_fails = assert_fails + 1;
        end

endmodule

bind ctrl_subsys_top ctrl_subsys_asserts u_asserts (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .gnt_i    (gnt),
    .m0_cyc_i (m0_cyc_i),
    .m1_cyc_i (m1_cyc_i),
    .m0_ack_i (m0_ack_o),
    .m0_err_i (m0_err_o),
    .m1_ack_i (m1_ack_o),
    .m1_err_i (m1_err_o)
);

/* verif/tb_ctrl_subsys.sv */
`timescale 1ns/1ps

module tb_ctrl_subsys;
    import intercon_pkg::*;

    // About 200 transfers at up to 8 cycles each, doubled
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int RAM_WORDS      = 2 ** CRATE_DEPTH_LOG2;

    logic                  clk;
    logic                  rst;
    logic                  cyc  [NUM_MASTERS];
    logic                  stb  [NUM_MASTERS];
    logic                  we   [NUM_MASTERS];
    logic [ADDR_WIDTH-1:0] adr  [NUM_MASTERS];
    logic [DATA_WIDTH-1:0] wdat [NUM_MASTERS];
    logic [SEL_WIDTH-1:0]  sel  [NUM_MASTERS];
    logic [DATA_WIDTH-1:0] rdat [NUM_MASTERS];
    logic                  ack  [NUM_MASTERS];
    logic                  err  [NUM_MASTERS];

    // Expected contents of both banks and the crate RAM
    logic [DATA_WIDTH-1:0] bank_model [2][BANK_WORDS];
    logic [DATA_WIDTH-1:0] ram_model  [RAM_WORDS];
    logic [31:0]           rng_state;
    int                    checks      = 0;
    int                    errors      = 0;
    int                    tests       = 0;
    int                    cycle_count = 0;

    ctrl_subsys_top UUT (
        .clk_i    (clk),
        .rst_i    (rst),
        .m0_cyc_i (cyc[0]),
        .m0_stb_i (stb[0]),
        .m0_we_i  (we[0]),
        .m0_adr_i (adr[0]),
        .m0_dat_i (wdat[0]),
        .m0_sel_i (sel[0]),
        .m0_dat_o (rdat[0]),
        .m0_ack_o (ack[0]),
        .m0_err_o (err[0]),
        .m1_cyc_i (cyc[1]),
        .m1_stb_i (stb[1]),
        .m1_we_i  (we[1]),
        .m1_adr_i (adr[1]),
        .m1_dat_i (wdat[1]),
        .m1_sel_i (sel[1]),
        .m1_dat_o (rdat[1]),
        .m1_ack_o (ack[1]),
        .m1_err_o (err[1])
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a transfer never finished", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Crate clear, region picks the bank, alias bits sit above the word index
    function automatic logic [ADDR_WIDTH-1:0] bank_addr(input int bank, input int word,
                                                        input int alias_n);
        logic [12:0] region;
        region = (bank == 1) ? REGION_BANK1 : REGION_BANK0;
        return {1'b0, region, 14'((alias_n << 5) | (word << 2))};
    endfunction

    // RAM index lives in offset bits 9:2, anything higher aliases
    function automatic logic [ADDR_WIDTH-1:0] crate_addr(input int idx, input int alias_n);
        return {1'b1, 27'((alias_n << 10) | (idx << 2))};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] merge_lanes(input logic [DATA_WIDTH-1:0] old_w,
                                                          input logic [DATA_WIDTH-1:0] new_w,
                                                          input logic [SEL_WIDTH-1:0] lanes);
        logic [DATA_WIDTH-1:0] res;
        res = old_w;
        for (int b = 0; b < SEL_WIDTH; b++) begin
            if (lanes[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // One classic cycle, entered and left 1 ns after a rising edge
    task automatic bus_xfer(input int port, input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data, input logic [SEL_WIDTH-1:0] lanes,
                            output logic [DATA_WIDTH-1:0] rd, output logic got_err);
        logic done;
        done       = 1'b0;
        rd         = '0;
        got_err    = 1'b0;
        cyc[port]  = 1'b1;
        stb[port]  = 1'b1;
        we[port]   = wr;
        adr[port]  = addr;
        wdat[port] = data;
        sel[port]  = lanes;
        while (!done) begin
            @(posedge clk);
            #1;
            if (ack[port] || err[port]) begin
                done    = 1'b1;
                rd      = rdat[port];
                got_err = err[port];
            end
        end
        cyc[port] = 1'b0;
        stb[port] = 1'b0;
        we[port]  = 1'b0;
        // Idle edge so the arbiter can hand the bus over
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input string test, input int port, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data, input logic [SEL_WIDTH-1:0] lanes);
        logic [DATA_WIDTH-1:0] rd;
        logic                  got_err;
        bus_xfer(port, 1'b1, addr, data, lanes, rd, got_err);
        checks++;
        assert (!got_err) else begin
            $display("test %s: write to %h on master %0d ended in err", test, addr, port);
            errors++;
        end
    endtask

    task automatic read_check(input string test, input int port, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] exp);
        logic [DATA_WIDTH-1:0] rd;
        logic                  got_err;
        bus_xfer(port, 1'b0, addr, '0, '1, rd, got_err);
        checks++;
        assert (!got_err && rd === exp) else begin
            if (got_err) begin
                $display("test %s: read from %h on master %0d ended in err", test, addr, port);
            end else begin
                $display("MISMATCH %s: expected %h, actual %h", test, exp, rd);
            end
            errors++;
        end
    endtask

    task automatic bank_stream(input string test, input int port, input int count);
        logic [31:0] data;
        logic [31:0] lanes_r;
        int          w;
        for (int i = 0; i < count; i++) begin
            w       = 1 + (i % (BANK_WORDS - 1));
            data    = next_rand();
            lanes_r = next_rand();
            write_word(test, port, bank_addr(port, w, i % 4), data, lanes_r[3:0]);
            bank_model[port][w] = merge_lanes(bank_model[port][w], data, lanes_r[3:0]);
            read_check(test, port, bank_addr(port, w, 0), bank_model[port][w]);
        end
    endtask

    task automatic report_test(input string test, input int err_before);
        tests++;
        $display("test %s finished with %0d errors", test, errors - err_before);
    endtask

    initial begin
        int                    start;
        int                    idx;
        int                    asrt;
        logic [31:0]           data;
        logic [31:0]           lanes_r;
        logic [DATA_WIDTH-1:0] rd;
        logic                  got_err;

        clk       = 1'b0;
        rst       = 1'b1;
        rng_state = 32'h00f1699b;
        for (int p = 0; p < NUM_MASTERS; p++) begin
            cyc[p]  = 1'b0;
            stb[p]  = 1'b0;
            we[p]   = 1'b0;
            adr[p]  = '0;
            wdat[p] = '0;
            sel[p]  = '0;
        end
        for (int w = 0; w < BANK_WORDS; w++) begin
            bank_model[0][w] = '0;
            bank_model[1][w] = '0;
        end
        bank_model[0][0] = BANK0_ID;
        bank_model[1][0] = BANK1_ID;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state, quiet bus then the ID words
        start = errors;
        repeat (3) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < NUM_MASTERS; p++) begin
                checks++;
                assert (!ack[p] && !err[p]) else begin
                    $display("test reset: master %0d got a response with no request", p);
                    errors++;
                end
            end
        end
        read_check("reset", 0, bank_addr(0, 0, 0), BANK0_ID);
        read_check("reset", 1, bank_addr(1, 0, 0), BANK1_ID);
        report_test("reset", start);

        // Two rounds so byte lanes merge over earlier data
        start = errors;
        for (int b = 0; b < 2; b++) begin
            bank_stream("regs", b, 2 * (BANK_WORDS - 1));
            write_word("regs", b, bank_addr(b, 0, 1), next_rand(), 4'hF);
            read_check("regs", b, bank_addr(b, 0, 0), bank_model[b][0]);
        end
        report_test("regs", start);

        // Full write first since RAM contents start unknown
        start = errors;
        for (int k = 0; k < 16; k++) begin
            idx  = (k * 37) % RAM_WORDS;
            data = next_rand();
            write_word("ram", k % 2, crate_addr(idx, 0), data, 4'hF);
            ram_model[idx] = data;
            data    = next_rand();
            lanes_r = next_rand();
            write_word("ram", k % 2, crate_addr(idx, 1), data, lanes_r[3:0]);
            ram_model[idx] = merge_lanes(ram_model[idx], data, lanes_r[3:0]);
            read_check("ram", (k + 1) % 2, crate_addr(idx, 2), ram_model[idx]);
        end
        for (int k = 0; k < 16; k++) begin
            idx = (k * 37) % RAM_WORDS;
            read_check("ram", 0, crate_addr(idx, 3), ram_model[idx]);
        end
        report_test("ram", start);

        // Region 5 with crate clear decodes to nothing
        start = errors;
        for (int p = 0; p < NUM_MASTERS; p++) begin
            bus_xfer(p, 1'b0, {1'b0, 13'd5, 14'h10}, '0, 4'hF, rd, got_err);
            checks++;
            assert (got_err) else begin
                $display("test unmapped: master %0d got ack instead of err", p);
                errors++;
            end
            read_check("unmapped", p, bank_addr(p, 0, 0), bank_model[p][0]);
        end
        report_test("unmapped", start);

        start = errors;
        fork
            bank_stream("dual", 0, 10);
            bank_stream("dual", 1, 10);
        join
        report_test("dual", start);

        repeat (4) @(posedge clk);
        asrt = UUT.u_asserts.assert_fails;
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, asrt);
        if (errors == 0 && asrt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/intercon_pkg.sv
hdl/wb_rr_arbiter.sv
intercon/bus_intercon.sv
hdl/ctrl_reg_bank.sv
hdl/crate_ram.sv
hdl/ctrl_subsys_top.sv
verif/ctrl_subsys_asserts.sv
verif/tb_ctrl_subsys.sv

/* Makefile */
TOP := tb_ctrl_subsys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
